//--- src/aggre_cfg_pkg.sv
`default_nettype none

package aggre_cfg_pkg;

    // ==============================
    // Aggregation mode
    // ==============================
    localparam int AGGRE_MODE_W = 2;
    localparam logic [AGGRE_MODE_W-1:0] AGGRE_MODE_CONCAT = 2'd1; // Line concatenation

    // ==============================
    // Register write port
    // ==============================
    localparam int CFG_ADDR_W = 2;
    localparam int CFG_DATA_W = 8;

    localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_MODE = 2'd0; // Mode and master pipe
    localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_PIPE = 2'd1; // Concat enables and mask
    localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_RDY  = 2'd2; // Ready bitmap

endpackage

`default_nettype wire

//--- src/aggre_sch_pkg.sv
`default_nettype none

package aggre_sch_pkg;

    localparam int PIPE_NUM   = 4;
    localparam int PIPE_IDX_W = 2;
    localparam int DT_W       = 6;  // CSI-2 data type

    // ==============================
    // Scheduler states
    // ==============================
    typedef enum logic [2:0] {
        SILENT        = 3'd0,
        START_CONCAT  = 3'd1,
        MASTER        = 3'd2,  // Grant the master pipe
        ORDER         = 3'd3,  // Grant next pipe from order list
        WAIT_ACK      = 3'd4,
        CLEAR_STATE   = 3'd5,
        WAIT_LINE_END = 3'd6
    } sch_state_t;

endpackage

`default_nettype wire

//--- src/sch_cfg_if.sv
`default_nettype none

interface sch_cfg_if
    import aggre_cfg_pkg::*, aggre_sch_pkg::*;
    ;

    logic [AGGRE_MODE_W-1:0] aggre_mode;
    logic [PIPE_NUM-1:0]     pipe_concat_en;
    logic [PIPE_NUM-1:0]     pipe_mask_bitmap;  // Masked pipes served by bpg
    logic [PIPE_IDX_W-1:0]   master_pipe;
    logic [PIPE_NUM-1:0]     pipe_rdy_bitmap;

    modport src (output aggre_mode, pipe_concat_en, pipe_mask_bitmap, master_pipe,
                 pipe_rdy_bitmap);
    modport chk (input aggre_mode, pipe_rdy_bitmap);
    modport sch (input pipe_concat_en, pipe_mask_bitmap, master_pipe);

endinterface

`default_nettype wire

//--- src/aggre_sch_regs.sv
`default_nettype none

module aggre_sch_regs
    import aggre_cfg_pkg::*, aggre_sch_pkg::*;
(
    input  logic                  aggre_clk,
    input  logic                  aggre_clk_rst_n,
    input  logic                  cfg_wr_en,
    input  logic [CFG_ADDR_W-1:0] cfg_addr,
    input  logic [CFG_DATA_W-1:0] cfg_wdata,
    sch_cfg_if.src                cfg
);

    logic [AGGRE_MODE_W-1:0] mode_q;
    logic [PIPE_IDX_W-1:0]   master_q;
    logic [PIPE_NUM-1:0]     concat_en_q;
    logic [PIPE_NUM-1:0]     mask_q;
    logic [PIPE_NUM-1:0]     rdy_q;

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            mode_q      <= '0;
            master_q    <= '0;
            concat_en_q <= '0;
            mask_q      <= '0;
            rdy_q       <= '0;
        end else if (cfg_wr_en) begin
            case (cfg_addr)
                CFG_ADDR_MODE: begin
                    mode_q   <= cfg_wdata[1:0];
                    master_q <= cfg_wdata[3:2];
                end
                CFG_ADDR_PIPE: begin
                    concat_en_q <= cfg_wdata[3:0];
                    mask_q      <= cfg_wdata[7:4];
                end
                CFG_ADDR_RDY: rdy_q <= cfg_wdata[3:0];
                default: ;  // Address 3 unmapped
            endcase
        end
    end

    assign cfg.aggre_mode       = mode_q;
    assign cfg.master_pipe      = master_q;
    assign cfg.pipe_concat_en   = concat_en_q;
    assign cfg.pipe_mask_bitmap = mask_q;
    assign cfg.pipe_rdy_bitmap  = rdy_q;

    // Write address must be resolved on every strobe
    a_wr_addr_known: assert property (
        @(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        cfg_wr_en |-> !$isunknown(cfg_addr)
    );

endmodule

`default_nettype wire

//--- src/data_type_align_check.sv
`default_nettype none

module data_type_align_check
    import aggre_cfg_pkg::*, aggre_sch_pkg::*;
(
    input  logic                           aggre_clk,
    input  logic                           aggre_clk_rst_n,
    sch_cfg_if.chk                         cfg,
    input  logic                           start_sch_pulse,
    input  logic [PIPE_NUM-1:0]            dt_vld,
    input  logic [PIPE_NUM-1:0][DT_W-1:0]  dt,
    output logic                           start_ok,
    output logic                           sch_data_type_align_fail_int
);

    logic [PIPE_NUM-1:0] part;      // Pipes taking part in the compare
    logic                mismatch;

    assign part = cfg.pipe_rdy_bitmap & dt_vld;

    // Any differing pair of participants fails
    always_comb begin
        mismatch = 1'b0;
        for (int i = 0; i < PIPE_NUM; i++) begin
            for (int j = i + 1; j < PIPE_NUM; j++) begin
                if (part[i] && part[j] && (dt[i] != dt[j]))
                    mismatch = 1'b1;
            end
        end
    end

    assign start_ok = start_sch_pulse & ~mismatch;

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n)
            sch_data_type_align_fail_int <= 1'b0;
        else
            sch_data_type_align_fail_int <= start_sch_pulse & mismatch &
                                            (cfg.aggre_mode == AGGRE_MODE_CONCAT);
    end

    // Interrupt only ever follows a start that was blocked
    a_fail_after_start: assert property (
        @(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        sch_data_type_align_fail_int |-> $past(start_sch_pulse && !start_ok)
    );

endmodule

`default_nettype wire

//--- src/concat_line_scheduler.sv
`default_nettype none

module concat_line_scheduler
    import aggre_sch_pkg::*;
(
    input  logic                aggre_clk,
    input  logic                aggre_clk_rst_n,
    sch_cfg_if.sch              cfg,
    input  logic                start_ok,
    input  logic [PIPE_NUM-1:0] ack,
    input  logic [PIPE_NUM-1:0] line_end,
    input  logic                bpg_ack,
    input  logic                bpg_line_end,
    output logic [PIPE_NUM-1:0] up_state,
    output logic                bpg_up_state,
    output logic                end_sch_pulse
);

    sch_state_t sch_cs;
    sch_state_t sch_ns;

    logic [PIPE_NUM-1:0]                  ack_en;
    logic [PIPE_NUM-1:0]                  line_end_en;
    logic [PIPE_NUM-1:0]                  grant;
    logic [PIPE_IDX_W-1:0]                cur_pipe;  // Pipe being served
    logic [PIPE_IDX_W-1:0]                cur_pos;   // Its slot in the order list
    logic [PIPE_NUM-1:0][PIPE_IDX_W-1:0]  ord_idx;
    logic [PIPE_NUM-1:0]                  ord_en;
    logic [PIPE_NUM-1:0][PIPE_IDX_W-1:0]  rot_idx;
    logic [PIPE_NUM-1:0]                  rot_en;
    logic [PIPE_IDX_W-1:0]                first_pos;
    logic                                 ack_hit;
    logic                                 line_end_hit;

    // ==============================
    // Source select by mask
    // ==============================
    always_comb begin
        for (int p = 0; p < PIPE_NUM; p++) begin
            ack_en[p]      = cfg.pipe_concat_en[p] &
                             (cfg.pipe_mask_bitmap[p] ? bpg_ack : ack[p]);
            line_end_en[p] = cfg.pipe_concat_en[p] &
                             (cfg.pipe_mask_bitmap[p] ? bpg_line_end : line_end[p]);
        end
    end

    assign ack_hit      = ack_en[cur_pipe];
    assign line_end_hit = line_end_en[cur_pipe];

    // ==============================
    // Order list
    // ==============================
    always_comb begin
        first_pos = '0;
        for (int j = PIPE_NUM - 1; j >= 0; j--) begin
            if (ord_en[j])
                first_pos = PIPE_IDX_W'(j);  // Lowest enabled slot wins
        end
    end

    // Entry after the served one leads and the served entry drops to the tail
    always_comb begin
        logic [PIPE_IDX_W-1:0] pos;
        for (int j = 0; j < PIPE_NUM; j++) begin
            pos        = cur_pos + PIPE_IDX_W'(j + 1);
            rot_idx[j] = ord_idx[pos];
            rot_en[j]  = ord_en[pos];
        end
        rot_en[PIPE_NUM-1] = 1'b0;
    end

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            ord_idx <= '0;
            ord_en  <= '0;
        end else if ((sch_cs == SILENT) && start_ok) begin
            for (int j = 0; j < PIPE_NUM; j++)
                ord_idx[j] <= PIPE_IDX_W'(j);
            ord_en <= cfg.pipe_concat_en;
        end else if (sch_ns == CLEAR_STATE) begin
            ord_idx <= rot_idx;
            ord_en  <= rot_en;
        end
    end

    // ==============================
    // FSM
    // ==============================
    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n)
            sch_cs <= SILENT;
        else
            sch_cs <= sch_ns;
    end

    always_comb begin
        sch_ns = sch_cs;
        case (sch_cs)
            SILENT:       if (start_ok) sch_ns = START_CONCAT;
            START_CONCAT: sch_ns = MASTER;
            MASTER, ORDER, WAIT_ACK: begin
                // Ack may land in the first grant cycle
                if (ack_hit)
                    sch_ns = CLEAR_STATE;
                else
                    sch_ns = WAIT_ACK;
            end
            CLEAR_STATE, WAIT_LINE_END: begin
                if (line_end_hit)
                    sch_ns = (|ord_en) ? ORDER : SILENT;
                else
                    sch_ns = WAIT_LINE_END;
            end
            default:      sch_ns = SILENT;
        endcase
    end

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            grant    <= '0;
            cur_pipe <= '0;
            cur_pos  <= '0;
        end else if (sch_ns == MASTER) begin
            grant    <= PIPE_NUM'(1) << cfg.master_pipe;
            cur_pipe <= cfg.master_pipe;
            cur_pos  <= cfg.master_pipe;  // Slot equals index in a fresh list
        end else if (sch_ns == ORDER) begin
            grant    <= PIPE_NUM'(1) << ord_idx[first_pos];
            cur_pipe <= ord_idx[first_pos];
            cur_pos  <= first_pos;
        end else if (sch_ns == CLEAR_STATE) begin
            grant    <= '0;
        end
    end

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n)
            end_sch_pulse <= 1'b0;
        else
            end_sch_pulse <= (sch_ns == SILENT) &&
                             ((sch_cs == CLEAR_STATE) || (sch_cs == WAIT_LINE_END));
    end

    // Masked grants go out to bpg
    assign up_state     = grant & ~cfg.pipe_mask_bitmap;
    assign bpg_up_state = |(grant & cfg.pipe_mask_bitmap);

    // Single grant and only while a grant state is active
    a_grant_onehot: assert property (
        @(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        $onehot0(grant) &&
        ((grant != '0) == (sch_cs inside {MASTER, ORDER, WAIT_ACK}))
    );

    a_master_enabled: assert property (
        @(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        start_ok |-> cfg.pipe_concat_en[cfg.master_pipe]
    );

endmodule

`default_nettype wire

//--- src/aggre_sch_top.sv
`default_nettype none

module aggre_sch_top
    import aggre_cfg_pkg::*, aggre_sch_pkg::*;
(
    input  logic                           aggre_clk,
    input  logic                           aggre_clk_rst_n,
    input  logic                           cfg_wr_en,
    input  logic [CFG_ADDR_W-1:0]          cfg_addr,
    input  logic [CFG_DATA_W-1:0]          cfg_wdata,
    input  logic                           start_sch_pulse,
    input  logic [PIPE_NUM-1:0]            dt_vld,
    input  logic [PIPE_NUM-1:0][DT_W-1:0]  dt,
    input  logic [PIPE_NUM-1:0]            ack,
    input  logic [PIPE_NUM-1:0]            line_end,
    input  logic                           bpg_ack,
    input  logic                           bpg_line_end,
    output logic [PIPE_NUM-1:0]            up_state,
    output logic                           bpg_up_state,
    output logic                           end_sch_pulse,
    output logic                           sch_data_type_align_fail_int
);

    logic start_ok;  // Start with aligned data types

    sch_cfg_if i_cfg_if ();

    aggre_sch_regs i_regs (
        .aggre_clk       (aggre_clk),
        .aggre_clk_rst_n (aggre_clk_rst_n),
        .cfg_wr_en       (cfg_wr_en),
        .cfg_addr        (cfg_addr),
        .cfg_wdata       (cfg_wdata),
        .cfg             (i_cfg_if.src)
    );

    data_type_align_check i_chk (
        .aggre_clk                    (aggre_clk),
        .aggre_clk_rst_n              (aggre_clk_rst_n),
        .cfg                          (i_cfg_if.chk),
        .start_sch_pulse              (start_sch_pulse),
        .dt_vld                       (dt_vld),
        .dt                           (dt),
        .start_ok                     (start_ok),
        .sch_data_type_align_fail_int (sch_data_type_align_fail_int)
    );

    concat_line_scheduler i_sch (
        .aggre_clk       (aggre_clk),
        .aggre_clk_rst_n (aggre_clk_rst_n),
        .cfg             (i_cfg_if.sch),
        .start_ok        (start_ok),
        .ack             (ack),
        .line_end        (line_end),
        .bpg_ack         (bpg_ack),
        .bpg_line_end    (bpg_line_end),
        .up_state        (up_state),
        .bpg_up_state    (bpg_up_state),
        .end_sch_pulse   (end_sch_pulse)
    );

endmodule

`default_nettype wire

//--- sim/tb_aggre_sch.sv
`default_nettype none

module tb_aggre_sch
    import aggre_cfg_pkg::*, aggre_sch_pkg::*;
    ;

    localparam int N_TEST  = 16;
    localparam int ROW_W   = 19;  // Words per golden row
    localparam int RST_CYC = 8;
    localparam int WD_CYC  = N_TEST * (4 * 2 * 5 + 20) + RST_CYC;
    localparam int GNT_TMO = 20;  // Cycles allowed for a grant to show up

    logic                          aggre_clk;
    logic                          aggre_clk_rst_n;
    logic                          cfg_wr_en;
    logic [CFG_ADDR_W-1:0]         cfg_addr;
    logic [CFG_DATA_W-1:0]         cfg_wdata;
    logic                          start_sch_pulse;
    logic [PIPE_NUM-1:0]           dt_vld;
    logic [PIPE_NUM-1:0][DT_W-1:0] dt;
    logic [PIPE_NUM-1:0]           ack;
    logic [PIPE_NUM-1:0]           line_end;
    logic                          bpg_ack;
    logic                          bpg_line_end;
    logic [PIPE_NUM-1:0]           up_state;
    logic                          bpg_up_state;
    logic                          end_sch_pulse;
    logic                          sch_data_type_align_fail_int;

    logic [7:0]  gold [0:N_TEST*ROW_W-1];
    int unsigned lcg_state = 73118;
    int          err_cnt   = 0;
    int          pass_cnt  = 0;
    int          mon_err   = 0;  // Errors seen by the output monitor
    int          end_cnt   = 0;
    int          fail_cnt  = 0;
    int          gnt_cyc   = 0;

    aggre_sch_top i_dut (.*);

    initial begin
        aggre_clk = 1'b0;
        forever #2 aggre_clk = ~aggre_clk;
    end

    initial begin
        repeat (WD_CYC) @(posedge aggre_clk);
        $display("Run stopped by the watchdog after %0d cycles", WD_CYC);
        $display("ERRORS FOUND");
        $finish;
    end

    // ==============================
    // Output monitor
    // ==============================
    always @(posedge aggre_clk) begin
        if (aggre_clk_rst_n) begin
            if (end_sch_pulse)
                end_cnt++;
            if (sch_data_type_align_fail_int)
                fail_cnt++;
            if (up_state != '0 || bpg_up_state)
                gnt_cyc++;
            assert ($countones({bpg_up_state, up_state}) <= 1)
            else begin
                $display("More than one grant output is high in the same cycle");
                mon_err++;
            end
        end
    end

    function automatic int next_delay();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'((lcg_state >> 16) % 6);  // 0 to 5 cycles
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else begin
            $display("Fail %s expected 0x%0h got 0x%0h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic write_reg(input logic [CFG_ADDR_W-1:0] addr,
                             input logic [CFG_DATA_W-1:0] data);
        cfg_wr_en = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge aggre_clk);
        cfg_wr_en = 1'b0;
    endtask

    // Waits for turn k, checks where it shows, then acks and ends the line
    task automatic serve_grant(input int base, input int k, input int len);
        int   n;
        int   exp_pipe;
        int   pipe;
        logic exp_bpg;
        logic use_bpg;
        logic got;
        n        = 0;
        pipe     = 0;
        exp_pipe = int'(gold[base + 15 + k]);
        exp_bpg  = gold[base + 3][exp_pipe];  // Masked pipe goes to bpg
        while (up_state == '0 && !bpg_up_state && n < GNT_TMO) begin
            @(negedge aggre_clk);
            n++;
        end
        got = (up_state != '0) || bpg_up_state;
        assert (got)
        else begin
            $display("No grant arrived for turn %0d of %0d", k, len);
            err_cnt++;
        end
        if (!got)
            return;
        check_val("up_state", 32'(exp_bpg ? 4'b0 : 4'b1 << exp_pipe), 32'(up_state));
        check_val("bpg_up_state", 32'(exp_bpg), 32'(bpg_up_state));
        use_bpg = bpg_up_state;
        for (int p = PIPE_NUM - 1; p >= 0; p--)
            if (up_state[p])
                pipe = p;
        repeat (next_delay()) @(negedge aggre_clk);
        if (use_bpg)
            bpg_ack = 1'b1;
        else
            ack[pipe] = 1'b1;
        @(negedge aggre_clk);
        ack     = '0;
        bpg_ack = 1'b0;
        check_val("up_state", 32'd0, 32'(up_state));  // Grant drops after ack
        check_val("bpg_up_state", 32'd0, 32'(bpg_up_state));
        repeat (next_delay()) @(negedge aggre_clk);
        if (use_bpg)
            bpg_line_end = 1'b1;
        else
            line_end[pipe] = 1'b1;
        @(negedge aggre_clk);
        line_end     = '0;
        bpg_line_end = 1'b0;
        check_val("end_sch_pulse", 32'(k == len - 1), 32'(end_sch_pulse));
    endtask

    // ==============================
    // One golden row
    // ==============================
    task automatic run_test(input int t);
        int base;
        int len;
        int err_base;
        int end_base;
        int fail_base;
        int gnt_base;
        base      = t * ROW_W;
        len       = int'(gold[base + 14]);
        err_base  = err_cnt + mon_err;
        end_base  = end_cnt;
        fail_base = fail_cnt;
        gnt_base  = gnt_cyc;
        write_reg(CFG_ADDR_MODE, {4'b0, gold[base + 1][1:0], gold[base][1:0]});
        write_reg(CFG_ADDR_PIPE, {gold[base + 3][3:0], gold[base + 2][3:0]});
        write_reg(CFG_ADDR_RDY, {4'b0, gold[base + 4][3:0]});
        for (int p = 0; p < PIPE_NUM; p++) begin
            dt_vld[p] = gold[base + 5 + p][0];
            dt[p]     = gold[base + 9 + p][DT_W-1:0];
        end
        start_sch_pulse = 1'b1;
        @(negedge aggre_clk);
        start_sch_pulse = 1'b0;
        check_val("sch_data_type_align_fail_int", 32'(gold[base + 13]),
                  32'(sch_data_type_align_fail_int));
        if (len == 0)
            repeat (12) @(negedge aggre_clk);  // Blocked, nothing may happen
        for (int k = 0; k < len; k++)
            serve_grant(base, k, len);
        @(negedge aggre_clk);
        check_val("end_sch_pulse cycles", 32'(len != 0), end_cnt - end_base);
        check_val("fail interrupt cycles", 32'(gold[base + 13]), fail_cnt - fail_base);
        if (len == 0)
            check_val("grant cycles", 32'd0, gnt_cyc - gnt_base);
        if (err_cnt + mon_err == err_base) begin
            pass_cnt++;
            $display("Test %0d done, %0d grants, ok", t, len);
        end else begin
            $display("Test %0d done, %0d errors", t, err_cnt + mon_err - err_base);
        end
    endtask

    initial begin
        aggre_clk_rst_n = 1'b0;
        cfg_wr_en       = 1'b0;
        cfg_addr        = '0;
        cfg_wdata       = '0;
        start_sch_pulse = 1'b0;
        dt_vld          = '0;
        dt              = '0;
        ack             = '0;
        line_end        = '0;
        bpg_ack         = 1'b0;
        bpg_line_end    = 1'b0;
        $readmemh("sim/sch_golden.txt", gold);
        repeat (RST_CYC) @(negedge aggre_clk);
        aggre_clk_rst_n = 1'b1;
        @(negedge aggre_clk);
        check_val("up_state", 32'd0, 32'(up_state));
        check_val("bpg_up_state", 32'd0, 32'(bpg_up_state));
        check_val("end_sch_pulse", 32'd0, 32'(end_sch_pulse));
        check_val("sch_data_type_align_fail_int", 32'd0, 32'(sch_data_type_align_fail_int));
        for (int t = 0; t < N_TEST; t++)
            run_test(t);
        $display("Tests %0d, passed %0d, failed %0d, errors %0d",
                 N_TEST, pass_cnt, N_TEST - pass_cnt, err_cnt + mon_err);
        if (err_cnt + mon_err == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/sch_golden.txt
// mode master concat_en mask rdy vld0 vld1 vld2 vld3 dt0 dt1 dt2 dt3 fail len
// ord0 ord1 ord2 ord3 follow on the same row, all hex, unused order slots 00
01 00 0f 00 0f 01 01 01 01 2b 2b 2b 2b 00 04 00 01 02 03
01 02 0f 00 0f 01 01 01 01 2a 2a 2a 2a 00 04 02 03 00 01
01 01 0b 00 0f 01 01 01 01 2b 2b 2b 2b 00 03 01 03 00 00
01 03 0f 05 0f 01 01 01 01 1e 1e 1e 1e 00 04 03 00 01 02
01 00 0f 0f 0f 01 01 01 01 2b 2b 2b 2b 00 04 00 01 02 03
01 02 04 00 0f 01 01 01 01 2a 2a 2a 2a 00 01 02 00 00 00
01 01 06 02 0f 01 01 01 01 2b 2b 2b 2b 00 02 01 02 00 00
01 00 0f 00 0f 01 01 01 01 2b 2b 2a 2b 01 00 00 00 00 00
00 00 0f 00 0f 01 01 01 01 2b 2b 2a 2b 00 00 00 00 00 00
02 00 0f 00 0f 01 01 01 01 2b 2b 2a 2b 00 00 00 00 00 00
00 01 0f 00 0f 01 01 01 01 2b 2b 2b 2b 00 04 01 02 03 00
01 00 0f 00 07 01 01 01 01 2b 2b 2b 1e 00 04 00 01 02 03
01 03 09 00 0f 01 00 01 01 2a 1e 2a 2a 00 02 03 00 00 00
01 01 0a 08 02 01 01 01 01 2b 2a 1e 12 00 02 01 03 00 00
03 00 05 01 0f 01 01 01 01 1e 1e 1e 1e 00 02 00 02 00 00
01 02 0f 04 03 01 01 01 01 2b 2a 2a 2a 01 00 00 00 00 00

//--- sim.f
src/aggre_cfg_pkg.sv
src/aggre_sch_pkg.sv
src/sch_cfg_if.sv
src/aggre_sch_regs.sv
src/data_type_align_check.sv
src/concat_line_scheduler.sv
src/aggre_sch_top.sv
sim/tb_aggre_sch.sv

//--- Makefile
# Verilator build and run for the concatenation scheduler

VERILATOR ?= verilator
TOP       ?= tb_aggre_sch
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q '^NO ERRORS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
